// File: common/param_pkg.sv
package param_pkg;

  // setting format
  localparam int PARAM_W     = 5;
  localparam int PARAM_COUNT = 4;
  localparam int SEL_W       = 2;

  // bus geometry, addresses are word indices
  localparam int WB_DW = 32;
  localparam int WB_AW = 4;
  localparam logic [WB_AW-1:0] ADDR_CTRL = '0;  // setting i at i+1

  // key timing in ms ticks
  localparam int DEBOUNCE_MS = 20;
  localparam int REPEAT_MS   = 100;
  localparam int DEB_CNT_W   = $clog2(DEBOUNCE_MS + 1);
  localparam int RPT_CNT_W   = $clog2(REPEAT_MS + DEBOUNCE_MS);

  // per-setting range and default
  localparam int PARAM_MIN     [PARAM_COUNT] = '{-8, 0, -3, 1};
  localparam int PARAM_MAX     [PARAM_COUNT] = '{7, 3, 3, 12};
  localparam int PARAM_DEFAULT [PARAM_COUNT] = '{0, 1, -1, 6};

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [WB_DW-SEL_W-2:0] rsvd;
    logic [SEL_W-1:0]       sel;
    logic                   restore;  // bit 0
  } ctrl_word_t;

  typedef logic signed [WB_DW-1:0] param_word_t;  // sign extended setting

  // one bus word, meaning set by address
  typedef union packed {
    ctrl_word_t  ctrl;
    param_word_t param;
  } wb_data_u;

  // limits of a PARAM_W signed field, for saturating wide loads
  localparam param_word_t WORD_SAT_MAX = param_word_t'(2 ** (PARAM_W - 1) - 1);
  localparam param_word_t WORD_SAT_MIN = param_word_t'(-(2 ** (PARAM_W - 1)));

  typedef struct packed {
    logic up;
    logic down;
  } step_t;

endpackage

// File: hdl/ms_tick_gen.sv
`timescale 1ns/10ps

module ms_tick_gen #(
  parameter int TICKS_PER_MS = 50_000
) (
  input  logic clk,
  input  logic resetn,
  output logic ms_tick
);

  typedef logic [$clog2(TICKS_PER_MS + 1)-1:0] cnt_t;

  cnt_t cnt;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cnt     <= '0;
      ms_tick <= 1'b0;
    end else if (cnt == cnt_t'(TICKS_PER_MS - 1)) begin
      cnt     <= '0;
      ms_tick <= 1'b1;  // one cycle per wrap
    end else begin
      cnt     <= cnt + cnt_t'(1);
      ms_tick <= 1'b0;
    end
  end

endmodule

// File: key_input/key_debounce.sv
`timescale 1ns/10ps

module key_debounce (
  input  logic clk,
  input  logic resetn,
  input  logic ms_tick,
  input  logic key_in,   // raw, active low
  output logic pressed,
  output logic change
);

  import param_pkg::*;

  logic [1:0]           key_sync;
  logic                 key_level;
  logic                 differ;
  logic [DEB_CNT_W-1:0] cnt;

  // two flop synchronizer, idles released
  always_ff @(posedge clk) begin
    if (!resetn) begin
      key_sync <= 2'b11;
    end else begin
      key_sync <= {key_sync[0], key_in};
    end
  end

  assign key_level = ~key_sync[1];  // high while held
  assign differ    = key_level != pressed;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cnt     <= '0;
      pressed <= 1'b0;
      change  <= 1'b0;
    end else begin
      change <= 1'b0;
      if (!differ) begin
        cnt <= '0;  // bounce back, start over
      end else if (ms_tick) begin
        if (cnt == DEB_CNT_W'(DEBOUNCE_MS)) begin
          // stable long enough, accept the new level
          cnt     <= '0;
          pressed <= ~pressed;
          change  <= 1'b1;
        end else begin
          cnt <= cnt + DEB_CNT_W'(1);
        end
      end
    end
  end

endmodule

// File: key_input/key_repeat.sv
`timescale 1ns/10ps

module key_repeat (
  input  logic             clk,
  input  logic             resetn,
  input  logic             ms_tick,
  input  logic             up_pressed,
  input  logic             up_change,
  input  logic             down_pressed,
  input  logic             down_change,
  output param_pkg::step_t step
);

  import param_pkg::*;

  logic [RPT_CNT_W-1:0] cnt;
  logic                 fresh_up;
  logic                 fresh_down;
  logic                 held;
  logic                 expire;
  logic                 hit_up;
  logic                 hit_down;

  always_comb begin
    fresh_up   = up_pressed & up_change;
    fresh_down = down_pressed & down_change;
    held       = up_pressed | down_pressed;
    expire     = held & ms_tick & (cnt == '0);
    hit_down   = fresh_down | (expire & down_pressed);
    hit_up     = (fresh_up | (expire & up_pressed)) & ~hit_down;  // down wins
  end

  // first repeat after REPEAT_MS+DEBOUNCE_MS, then every REPEAT_MS
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cnt <= RPT_CNT_W'(REPEAT_MS + DEBOUNCE_MS - 1);
    end else if (fresh_up || fresh_down || !held) begin
      cnt <= RPT_CNT_W'(REPEAT_MS + DEBOUNCE_MS - 1);
    end else if (ms_tick) begin
      if (cnt == '0) begin
        cnt <= RPT_CNT_W'(REPEAT_MS - 1);
      end else begin
        cnt <= cnt - RPT_CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step <= '0;
    end else begin
      step.up   <= hit_up;
      step.down <= hit_down;
    end
  end

endmodule

// File: param_cell/param_cell_signed_loop.sv
`timescale 1ns/10ps

module param_cell_signed_loop #(
  parameter int RANGE_MIN     = 0,
  parameter int RANGE_MAX     = 1,
  parameter int DEFAULT_VALUE = 0
) (
  input  logic                                 clk,
  input  logic                                 resetn,
  input  logic                                 selected,
  input  logic                                 restore,
  input  logic                                 load_valid,
  input  logic signed [param_pkg::PARAM_W-1:0] load_data,
  input  param_pkg::step_t                     step,
  output logic signed [param_pkg::PARAM_W-1:0] value
);

  import param_pkg::*;

  logic signed [PARAM_W-1:0] lo;
  logic signed [PARAM_W-1:0] hi;

  assign lo = PARAM_W'(RANGE_MIN);
  assign hi = PARAM_W'(RANGE_MAX);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      value <= PARAM_W'(DEFAULT_VALUE);
    end else if (load_valid) begin
      // host load, clamp into range
      if (load_data < lo) begin
        value <= lo;
      end else if (load_data > hi) begin
        value <= hi;
      end else begin
        value <= load_data;
      end
    end else if (selected) begin
      if (restore) begin
        value <= PARAM_W'(DEFAULT_VALUE);
      end else if (step.down) begin
        if (value <= lo) begin
          value <= hi;  // wrap to top
        end else begin
          value <= value - PARAM_W'(1);
        end
      end else if (step.up) begin
        if (value >= hi) begin
          value <= lo;  // wrap to bottom
        end else begin
          value <= value + PARAM_W'(1);
        end
      end
    end
  end

endmodule

// File: hdl/param_bank_wb.sv
`timescale 1ns/10ps

module param_bank_wb (
  input  logic               clk,
  input  logic               resetn,
  input  param_pkg::wb_req_t wb_req,
  output param_pkg::wb_rsp_t wb_rsp,
  input  param_pkg::step_t   step
);

  import param_pkg::*;

  logic                      ack_q;
  logic [WB_DW-1:0]          rd_dat_q;
  logic [SEL_W-1:0]          sel_q;
  logic [SEL_W-1:0]          sel_now;
  logic                      req_hit;
  logic                      wr_hit;
  logic                      wr_ctrl;
  logic                      restore;
  wb_data_u                  wdata;
  wb_data_u                  rdata;
  logic signed [PARAM_W-1:0] load_sat;
  logic signed [PARAM_W-1:0] value [PARAM_COUNT];

  assign wdata   = wb_req.dat;
  assign req_hit = wb_req.cyc & wb_req.stb & ~ack_q;  // idle cycle after each ack
  assign wr_hit  = req_hit & wb_req.we;
  assign wr_ctrl = wr_hit & (wb_req.adr == ADDR_CTRL);
  assign restore = wr_ctrl & wdata.ctrl.restore;
  assign sel_now = wr_ctrl ? wdata.ctrl.sel : sel_q;  // restore acts on new selection

  // saturate the wide word to the cell width before the range clamp
  always_comb begin
    if (wdata.param > WORD_SAT_MAX) begin
      load_sat = PARAM_W'(WORD_SAT_MAX);
    end else if (wdata.param < WORD_SAT_MIN) begin
      load_sat = PARAM_W'(WORD_SAT_MIN);
    end else begin
      load_sat = wdata.param[PARAM_W-1:0];
    end
  end

  always_comb begin
    rdata = '0;  // unused addresses read zero
    if (wb_req.adr == ADDR_CTRL) begin
      rdata.ctrl.sel = sel_q;
    end
    for (int k = 0; k < PARAM_COUNT; k++) begin
      if (wb_req.adr == WB_AW'(k + 1)) begin
        rdata.param = param_word_t'(value[k]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ack_q <= 1'b0;
      sel_q <= '0;
    end else begin
      ack_q <= req_hit;
      if (wr_ctrl) begin
        sel_q <= wdata.ctrl.sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_dat_q <= rdata;
  end

  assign wb_rsp = '{ack: ack_q, dat: rd_dat_q};

  for (genvar i = 0; i < PARAM_COUNT; i++) begin : g_cell
    param_cell_signed_loop #(
      .RANGE_MIN     (PARAM_MIN[i]),
      .RANGE_MAX     (PARAM_MAX[i]),
      .DEFAULT_VALUE (PARAM_DEFAULT[i])
    ) u_cell (
      .clk        (clk),
      .resetn     (resetn),
      .selected   (sel_now == SEL_W'(i)),
      .restore    (restore),
      .load_valid (wr_hit && (wb_req.adr == WB_AW'(i + 1))),
      .load_data  (load_sat),
      .step       (step),
      .value      (value[i])
    );
  end

endmodule

// File: hdl/param_panel_top.sv
`timescale 1ns/10ps

module param_panel_top #(
  parameter int TICKS_PER_MS = 50_000
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic               key_up,    // active low
  input  logic               key_down,  // active low
  input  param_pkg::wb_req_t wb_req,
  output param_pkg::wb_rsp_t wb_rsp
);

  import param_pkg::*;

  logic  ms_tick;
  logic  up_pressed;
  logic  up_change;
  logic  down_pressed;
  logic  down_change;
  step_t step;

  ms_tick_gen #(
    .TICKS_PER_MS (TICKS_PER_MS)
  ) u_tick (
    .clk     (clk),
    .resetn  (resetn),
    .ms_tick (ms_tick)
  );

  key_debounce u_deb_up (
    .clk     (clk),
    .resetn  (resetn),
    .ms_tick (ms_tick),
    .key_in  (key_up),
    .pressed (up_pressed),
    .change  (up_change)
  );

  key_debounce u_deb_down (
    .clk     (clk),
    .resetn  (resetn),
    .ms_tick (ms_tick),
    .key_in  (key_down),
    .pressed (down_pressed),
    .change  (down_change)
  );

  key_repeat u_repeat (
    .clk          (clk),
    .resetn       (resetn),
    .ms_tick      (ms_tick),
    .up_pressed   (up_pressed),
    .up_change    (up_change),
    .down_pressed (down_pressed),
    .down_change  (down_change),
    .step         (step)
  );

  param_bank_wb u_bank (
    .clk    (clk),
    .resetn (resetn),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .step   (step)
  );

endmodule

// File: sim/tb_param_panel.sv
`timescale 1ns/10ps

module tb_param_panel;

  import param_pkg::*;

  localparam int TICKS_PER_MS   = 4;
  localparam int TIMEOUT_CYCLES = 60000;
  localparam int HOLD_MS        = 520;

  logic    clk;
  logic    resetn;
  logic    key_up;
  logic    key_down;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int model [PARAM_COUNT];  // expected settings
  int sel_model;
  int cycles = 0;

  param_panel_top #(
    .TICKS_PER_MS (TICKS_PER_MS)
  ) DUT (
    .clk      (clk),
    .resetn   (resetn),
    .key_up   (key_up),
    .key_down (key_down),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "check failed");
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  ack_single: assert property (@(posedge clk) disable iff (!resetn) wb_rsp.ack |=> !wb_rsp.ack)
    else report_error("ack high on two consecutive cycles");

  function automatic int clamp_value(input int s, input int v);
    if (v < PARAM_MIN[s]) return PARAM_MIN[s];
    if (v > PARAM_MAX[s]) return PARAM_MAX[s];
    return v;
  endfunction

  function automatic int step_up_value(input int s, input int v);
    return (v >= PARAM_MAX[s]) ? PARAM_MIN[s] : v + 1;
  endfunction

  function automatic int step_down_value(input int s, input int v);
    return (v <= PARAM_MIN[s]) ? PARAM_MAX[s] : v - 1;
  endfunction

  task automatic wb_transfer(input logic we, input logic [WB_AW-1:0] adr,
                             input logic [WB_DW-1:0] dat, output logic [WB_DW-1:0] rd);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do begin
      @(posedge clk);
    end while (!wb_rsp.ack);
    rd = wb_rsp.dat;  // valid while ack high
    wb_req <= '0;
  endtask

  task automatic write_setting(input int s, input int v);
    logic [WB_DW-1:0] rd;
    wb_transfer(1'b1, WB_AW'(s + 1), WB_DW'(v), rd);
    model[s] = clamp_value(s, v);
  endtask

  task automatic write_ctrl(input int sel, input logic restore);
    logic [WB_DW-1:0] rd;
    wb_data_u         w;
    w              = '0;
    w.ctrl.sel     = SEL_W'(sel);
    w.ctrl.restore = restore;
    wb_transfer(1'b1, ADDR_CTRL, w, rd);
    sel_model = sel;
    if (restore) model[sel] = PARAM_DEFAULT[sel];
  endtask

  task automatic check_all(input string tag);
    logic [WB_DW-1:0] rd;
    wb_data_u         exp_ctrl;
    for (int k = 0; k < PARAM_COUNT; k++) begin
      wb_transfer(1'b0, WB_AW'(k + 1), '0, rd);
      assert ($signed(rd) == model[k])
        else report_error($sformatf("%s: setting %0d read %0d, expected %0d",
                                    tag, k, $signed(rd), model[k]));
    end
    exp_ctrl          = '0;
    exp_ctrl.ctrl.sel = SEL_W'(sel_model);
    wb_transfer(1'b0, ADDR_CTRL, '0, rd);
    assert (rd == exp_ctrl)
      else report_error($sformatf("%s: control read %h, expected %h", tag, rd, exp_ctrl));
  endtask

  // raw key low for a number of cycles and then released
  task automatic press_key(input logic up, input int low_cycles);
    @(posedge clk);
    if (up) key_up <= 1'b0;
    else key_down <= 1'b0;
    repeat (low_cycles) @(posedge clk);
    key_up   <= 1'b1;
    key_down <= 1'b1;
  endtask

  task automatic wait_ms(input int ms);
    repeat (ms * TICKS_PER_MS) @(posedge clk);
  endtask

  initial begin
    logic [WB_DW-1:0] rd;
    int               s;
    int               v;
    int               n_exp;
    logic             found;

    resetn   = 1'b0;
    key_up   = 1'b1;
    key_down = 1'b1;
    wb_req   = '0;
    void'($urandom(32'h3d68));
    for (int k = 0; k < PARAM_COUNT; k++) model[k] = PARAM_DEFAULT[k];
    sel_model = 0;
    repeat (8) @(posedge clk);
    resetn <= 1'b1;

    // reset state
    check_all("reset");
    wb_transfer(1'b0, WB_AW'(PARAM_COUNT + 2), '0, rd);
    assert (rd == '0) else report_error($sformatf("unused address read %h", rd));

    // clamped loads
    for (int n = 0; n < 16; n++) begin
      s = int'($urandom_range(PARAM_COUNT - 1));
      v = int'($urandom_range(80)) - 40;
      write_setting(s, v);
      check_all("load");
    end

    // single steps from max to hit both wraps
    for (int k = 0; k < PARAM_COUNT; k++) begin
      write_ctrl(k, 1'b0);
      write_setting(k, PARAM_MAX[k]);
      press_key(1'b1, 40 * TICKS_PER_MS);
      wait_ms(30);
      model[k] = step_up_value(k, model[k]);
      check_all("step up");
      press_key(1'b0, 40 * TICKS_PER_MS);
      wait_ms(30);
      model[k] = step_down_value(k, model[k]);
      check_all("step down wrap");
      press_key(1'b0, 40 * TICKS_PER_MS);
      wait_ms(30);
      model[k] = step_down_value(k, model[k]);
      check_all("step down");
    end

    // held auto-repeat on the wide setting
    write_ctrl(3, 1'b1);
    check_all("repeat start");
    press_key(1'b1, HOLD_MS * TICKS_PER_MS);
    wait_ms(30);
    n_exp = 1 + (HOLD_MS - REPEAT_MS - DEBOUNCE_MS) / REPEAT_MS + 1;  // press step plus repeats
    v = model[3];
    for (int k = 0; k < n_exp - 1; k++) v = step_up_value(3, v);
    wb_transfer(1'b0, WB_AW'(4), '0, rd);
    found = 1'b0;
    for (int k = 0; k < 3; k++) begin
      if ($signed(rd) == v) found = 1'b1;
      v = step_up_value(3, v);
    end
    assert (found)
      else report_error($sformatf("repeat: setting 3 read %0d, outside %0d +-1 steps from %0d",
                                  $signed(rd), n_exp, model[3]));
    write_setting(3, model[3]);
    check_all("repeat end");

    // restore one setting at a time
    for (int k = 0; k < PARAM_COUNT; k++) write_setting(k, PARAM_MAX[k]);
    for (int k = 0; k < PARAM_COUNT; k++) begin
      write_ctrl(k, 1'b1);
      check_all("restore");
    end

    // short glitches on both keys
    for (int n = 0; n < 24; n++) begin
      press_key($urandom_range(1) == 1,
                int'($urandom_range((DEBOUNCE_MS - 2) * TICKS_PER_MS - 1, 1)));
      repeat (int'($urandom_range(40, 1))) @(posedge clk);
    end
    wait_ms(30);
    check_all("bounce");

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: verilog.f
common/param_pkg.sv
hdl/ms_tick_gen.sv
key_input/key_debounce.sv
key_input/key_repeat.sv
param_cell/param_cell_signed_loop.sv
hdl/param_bank_wb.sv
hdl/param_panel_top.sv
sim/tb_param_panel.sv

// File: Makefile
# Verilator build for the parameter panel

VERILATOR  ?= verilator
TOP        := tb_param_panel
RTL_TOP    := param_panel_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/10ps
SIM_FLAGS  := --binary $(COMMON) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only $(COMMON)

.PHONY: all lint sim clean

all: sim

# lint the design top and the testbench top
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run, a $$fatal in the run gives a failing exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
